// ==== bench/rv_pipe_testdata.txt ====
// Columns: instruction word, expected rd, expected result, expected illegal flag
// All hex, one instruction per line, retired in this order
00500093 01 00000005 0 // addi x1, x0, 5
ffd00113 02 fffffffd 0 // addi x2, x0, -3
002081b3 03 00000002 0 // add  x3, x1, x2
40208233 04 00000008 0 // sub  x4, x1, x2
0020f2b3 05 00000005 0 // and  x5, x1, x2
0020e333 06 fffffffd 0 // or   x6, x1, x2
0020c3b3 07 fffffff8 0 // xor  x7, x1, x2
00409433 08 00000500 0 // sll  x8, x1, x4
001154b3 09 07ffffff 0 // srl  x9, x2, x1
00112533 0a 00000001 0 // slt  x10, x2, x1
12345637 0c 12345000 0 // lui  x12, 0x12345
67866693 0d 12345678 0 // ori  x13, x12, 0x678
0ff6f713 0e 00000078 0 // andi x14, x13, 0xff
fff6c793 0f edcba987 0 // xori x15, x13, -1
ffe12813 10 00000001 0 // slti x16, x2, -2
00708013 00 0000000c 0 // addi x0, x1, 7
000068b3 11 00000000 0 // or   x17, x0, x0
ffffffff 00 00000000 1 // unknown opcode
022081b3 00 00000000 1 // mul  x3, x1, x2
00018933 12 00000002 0 // add  x18, x3, x0
00198993 13 00000001 0 // addi x19, x19, 1
00198993 13 00000002 0 // addi x19, x19, 1
00198993 13 00000003 0 // addi x19, x19, 1
00209a33 14 a0000000 0 // sll  x20, x1, x2
00001b37 16 00001000 0 // lui  x22, 0x1
00002b37 16 00002000 0 // lui  x22, 0x2
00003b37 16 00003000 0 // lui  x22, 0x3
000b0bb3 17 00003000 0 // add  x23, x22, x0

// ==== filelist.f ====
logic/rv_pipe_pkg.sv
logic/fetch_port.sv
logic/inst_decoder.sv
logic/register_file.sv
logic/alu_stage.sv
logic/writeback_stage.sv
logic/rv_pipe_top.sv
bench/tb_clock_gen.sv
bench/rv_pipe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing --top-module rv_pipe_tb \
        -f filelist.f --Mdir "$build_dir" -o rv_pipe_sim; then
    echo "Verilator build failed"
    exit 1
fi

"$build_dir/rv_pipe_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if ! grep -qx "Test passed" "$log_file"; then
    echo "Pass message not found in $log_file"
    exit 1
fi
exit 0

// ==== bench/rv_pipe_tb.sv ====
module rv_pipe_tb;

    localparam int MAX_INSTS = 64;
    localparam int COLS      = 4;
    localparam int TIMEOUT   = 200;

    logic                 clk;
    logic                 rst;
    logic                 inst_req;
    rv_pipe_pkg::word_t   inst_word;
    logic                 inst_ack;
    logic                 ret_req;
    rv_pipe_pkg::retire_t ret_data;
    logic                 ret_ack;

    // Columns per line: word, rd, result, illegal
    logic [31:0]          test_mem [MAX_INSTS * COLS];
    int                   n_insts;
    int                   retired;
    logic [31:0]          rng;

    // Port samples from the previous falling edge
    logic                 req_seen;
    logic                 ack_seen;
    logic                 ret_req_seen;
    logic                 ret_ack_seen;
    rv_pipe_pkg::retire_t ret_seen;

    tb_clock_gen clk0 (
        .clk_o (clk),
        .rst_o (rst)
    );

    rv_pipe_top dut0 (
        .clk_i      (clk),
        .rst_i      (rst),
        .inst_req_i (inst_req),
        .inst_i     (inst_word),
        .inst_ack_o (inst_ack),
        .ret_req_o  (ret_req),
        .ret_o      (ret_data),
        .ret_ack_i  (ret_ack)
    );

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s at time %0t", reason, $time);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------------------------
    // Instruction port, one full four-phase cycle per word
    // ------------------------------------------------------------------

    task automatic send_inst(input rv_pipe_pkg::word_t word);
        int cycles;
        @(posedge clk);
        inst_word <= word;
        inst_req  <= 1'b1;
        cycles = 0;
        // Ack may be late under back-pressure
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("Instruction port hung, inst_ack_o never rose");
            end
        end while (!inst_ack);
        @(posedge clk);
        inst_req <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("Instruction port hung, inst_ack_o never fell");
            end
        end while (inst_ack);
    endtask

    // ------------------------------------------------------------------
    // Retire port, checks one result and acks after a random delay
    // ------------------------------------------------------------------

    task automatic retire_one(input int idx);
        int cycles;
        int delay;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("Retire port hung, ret_req_o never rose");
            end
        end while (!ret_req);

        // Retirements come back in data file order
        check_value("ret_o.rd", 32'(ret_data.rd), test_mem[COLS * idx + 1]);
        check_value("ret_o.result", ret_data.result, test_mem[COLS * idx + 2]);
        check_value("ret_o.illegal", 32'(ret_data.illegal), test_mem[COLS * idx + 3]);

        rng   = xorshift32(rng);
        delay = int'(rng[1:0]);
        repeat (delay) @(posedge clk);
        @(posedge clk);
        ret_ack <= 1'b1;

        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("Retire port hung, ret_req_o never fell");
            end
        end while (ret_req);
        @(posedge clk);
        ret_ack <= 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Handshake rule monitor
    // ------------------------------------------------------------------

    always @(negedge clk) begin
        if (!rst) begin
            req_seen     = 1'b0;
            ack_seen     = 1'b0;
            ret_req_seen = 1'b0;
            ret_ack_seen = 1'b0;
            retired      = 0;
        end else begin
            // Ack rises only on a request seen the cycle before
            if (inst_ack && !ack_seen && !req_seen) begin
                abort_run("inst_ack_o rose while inst_req_i was low");
            end
            // Request and data frozen until the ack is seen
            if (ret_req_seen && !ret_ack_seen) begin
                check_value("ret_req_o", 32'(ret_req), 32'd1);
                check_value("ret_o.rd", 32'(ret_data.rd), 32'(ret_seen.rd));
                check_value("ret_o.result", ret_data.result, ret_seen.result);
                check_value("ret_o.illegal", 32'(ret_data.illegal), 32'(ret_seen.illegal));
            end
            // Each rising retire request counts once
            if (ret_req && !ret_req_seen) begin
                retired++;
            end
            req_seen     = inst_req;
            ack_seen     = inst_ack;
            ret_req_seen = ret_req;
            ret_ack_seen = ret_ack;
            ret_seen     = ret_data;
        end
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        int cycles;
        inst_req  = 1'b0;
        inst_word = '0;
        ret_ack   = 1'b0;
        rng       = 32'd2;
        n_insts   = 0;

        // Unused slots hold a value no rd column can match
        for (int i = 0; i < MAX_INSTS * COLS; i++) begin
            test_mem[i] = 32'hff00_0000 | 32'(i);
        end
        $readmemh("bench/rv_pipe_testdata.txt", test_mem);
        while (n_insts < MAX_INSTS && test_mem[COLS * n_insts + 1][31:24] != 8'hff) begin
            n_insts++;
        end
        if (n_insts == 0) begin
            abort_run("Data file holds no instructions");
        end

        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("Reset was never released");
            end
        end while (!rst);

        fork
            begin
                for (int k = 0; k < n_insts; k++) begin
                    send_inst(test_mem[COLS * k]);
                end
            end
            begin
                for (int k = 0; k < n_insts; k++) begin
                    retire_one(k);
                end
            end
        join

        // No extra retirement after the last one
        repeat (10) begin
            @(negedge clk);
            check_value("ret_req_o", 32'(ret_req), 32'd0);
        end

        if (retired == n_insts) begin
            $display("Test passed");
            $finish;
        end else begin
            check_value("retire count", 32'(retired), 32'(n_insts));
        end
    end

endmodule

// ==== bench/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // Period of 4, first rising edge at time 2
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Active-low reset held over two rising edges
    initial begin
        rst_o = 1'b0;
        repeat (2) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

// ==== logic/rv_pipe_top.sv ====
module rv_pipe_top (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 inst_req_i,
    input  rv_pipe_pkg::word_t   inst_i,
    output logic                 inst_ack_o,
    output logic                 ret_req_o,
    output rv_pipe_pkg::retire_t ret_o,
    input  logic                 ret_ack_i
);

    logic                  fetch_valid;
    rv_pipe_pkg::word_t    fetch_word;
    rv_pipe_pkg::dec_pkt_t dec_pkt;
    rv_pipe_pkg::exe_pkt_t exe_pkt;
    rv_pipe_pkg::wb_pkt_t  wb_pkt;
    logic                  wb_hold;
    logic                  issue_stall;
    logic                  wb_we;
    rv_pipe_pkg::reg_idx_t wb_rd;
    rv_pipe_pkg::word_t    wb_data;

    // Front end stops on write-back busy or issue hazard
    wire front_hold = wb_hold | issue_stall;

    // ------------------------------------------------------------------
    // Stages
    // ------------------------------------------------------------------

    fetch_port fetch0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .inst_req_i   (inst_req_i),
        .inst_i       (inst_i),
        .inst_ack_o   (inst_ack_o),
        .hold_i       (front_hold),
        .inst_valid_o (fetch_valid),
        .inst_word_o  (fetch_word)
    );

    inst_decoder dec0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .hold_i       (front_hold),
        .inst_valid_i (fetch_valid),
        .inst_word_i  (fetch_word),
        .dec_o        (dec_pkt)
    );

    register_file rf0 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .dec_i     (dec_pkt),
        .hold_i    (wb_hold),
        .wb_we_i   (wb_we),
        .wb_rd_i   (wb_rd),
        .wb_data_i (wb_data),
        .exe_o     (exe_pkt),
        .stall_o   (issue_stall)
    );

    alu_stage alu0 (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .hold_i (wb_hold),
        .exe_i  (exe_pkt),
        .wb_o   (wb_pkt)
    );

    writeback_stage wb0 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wb_i      (wb_pkt),
        .hold_o    (wb_hold),
        .wb_we_o   (wb_we),
        .wb_rd_o   (wb_rd),
        .wb_data_o (wb_data),
        .ret_req_o (ret_req_o),
        .ret_o     (ret_o),
        .ret_ack_i (ret_ack_i)
    );

endmodule

// ==== logic/writeback_stage.sv ====
module writeback_stage (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  rv_pipe_pkg::wb_pkt_t  wb_i,
    output logic                  hold_o,
    output logic                  wb_we_o,
    output rv_pipe_pkg::reg_idx_t wb_rd_o,
    output rv_pipe_pkg::word_t    wb_data_o,
    output logic                  ret_req_o,
    output rv_pipe_pkg::retire_t  ret_o,
    input  logic                  ret_ack_i
);

    logic                 occ_q;
    logic                 req_q;
    logic                 we_q;
    logic                 capture;
    rv_pipe_pkg::retire_t ret_q;

    // Take a result only when fully idle
    assign capture = wb_i.valid && !occ_q;

    // ------------------------------------------------------------------
    // Retire handshake
    //   occ & req   waiting for ack high
    //   occ & !req  waiting for ack low
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            occ_q <= 1'b0;
            req_q <= 1'b0;
            we_q  <= 1'b0;
        end else begin
            // Single write pulse alongside req rising
            we_q <= capture && wb_i.write_rd && (wb_i.rd != '0);

            if (capture) begin
                occ_q <= 1'b1;
                req_q <= 1'b1;
            end else if (req_q) begin
                if (ret_ack_i) begin
                    req_q <= 1'b0;
                end
            end else if (occ_q && !ret_ack_i) begin
                occ_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            ret_q.rd      <= wb_i.rd;
            ret_q.result  <= wb_i.result;
            ret_q.illegal <= wb_i.illegal;
        end
    end

    assign hold_o    = occ_q;
    assign ret_req_o = req_q;
    assign ret_o     = ret_q;
    assign wb_we_o   = we_q;
    assign wb_rd_o   = ret_q.rd;
    assign wb_data_o = ret_q.result;

endmodule

// ==== logic/alu_stage.sv ====
module alu_stage (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  hold_i,
    input  rv_pipe_pkg::exe_pkt_t exe_i,
    output rv_pipe_pkg::wb_pkt_t  wb_o
);

    rv_pipe_pkg::word_t result;
    logic [4:0]         shamt;
    logic               less;

    // Only low 5 bits count for shifts
    assign shamt = exe_i.op_b[4:0];
    // Signed compare for SLT and SLTI
    assign less  = $signed(exe_i.op_a) < $signed(exe_i.op_b);

    always_comb begin
        case (exe_i.alu_op)
            rv_pipe_pkg::ADD:    result = exe_i.op_a + exe_i.op_b;
            rv_pipe_pkg::SUB:    result = exe_i.op_a - exe_i.op_b;
            rv_pipe_pkg::AND:    result = exe_i.op_a & exe_i.op_b;
            rv_pipe_pkg::OR:     result = exe_i.op_a | exe_i.op_b;
            rv_pipe_pkg::XOR:    result = exe_i.op_a ^ exe_i.op_b;
            rv_pipe_pkg::SLL:    result = exe_i.op_a << shamt;
            rv_pipe_pkg::SRL:    result = exe_i.op_a >> shamt;
            rv_pipe_pkg::SLT:    result = {31'b0, less};
            rv_pipe_pkg::PASS_B: result = exe_i.op_b;
            default:             result = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // Output register, frozen while write-back is busy
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wb_o.valid <= 1'b0;
        end else if (!hold_i) begin
            wb_o.valid    <= exe_i.valid;
            wb_o.rd       <= exe_i.rd;
            wb_o.write_rd <= exe_i.write_rd;
            // Illegal ops report zero result
            wb_o.result   <= exe_i.illegal ? '0 : result;
            wb_o.illegal  <= exe_i.illegal;
        end
    end

endmodule

// ==== logic/register_file.sv ====
module register_file (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  rv_pipe_pkg::dec_pkt_t dec_i,
    input  logic                  hold_i,
    input  logic                  wb_we_i,
    input  rv_pipe_pkg::reg_idx_t wb_rd_i,
    input  rv_pipe_pkg::word_t    wb_data_i,
    output rv_pipe_pkg::exe_pkt_t exe_o,
    output logic                  stall_o
);

    rv_pipe_pkg::word_t     regs_q [32];
    rv_pipe_pkg::pend_cnt_t pend_q [32];

    rv_pipe_pkg::exe_pkt_t  exe_d;
    rv_pipe_pkg::word_t     rs1_data;
    rv_pipe_pkg::word_t     rs2_data;
    logic                   rs1_busy;
    logic                   rs2_busy;
    logic                   rd_full;
    logic                   issue;
    logic                   inc_cnt;
    logic                   dec_cnt;
    logic                   same_reg;

    // ------------------------------------------------------------------
    // Hazard check
    // ------------------------------------------------------------------

    // Any pending writer on a source means the value is stale
    assign rs1_busy = dec_i.read_rs1 && (pend_q[dec_i.rs1] != '0);
    assign rs2_busy = dec_i.read_rs2 && (pend_q[dec_i.rs2] != '0);
    // Counter would wrap past 3
    assign rd_full  = dec_i.write_rd && (pend_q[dec_i.rd] == '1);

    assign stall_o  = dec_i.valid && (rs1_busy || rs2_busy || rd_full);
    assign issue    = dec_i.valid && !stall_o && !hold_i;

    // x0 is never tracked
    assign inc_cnt  = issue && dec_i.write_rd && (dec_i.rd != '0);
    assign dec_cnt  = wb_we_i && (wb_rd_i != '0);
    assign same_reg = (dec_i.rd == wb_rd_i);

    // ------------------------------------------------------------------
    // Operand read and issue packet
    // ------------------------------------------------------------------

    assign rs1_data = regs_q[dec_i.rs1];
    assign rs2_data = regs_q[dec_i.rs2];

    always_comb begin
        // Bubble while stalled
        exe_d.valid    = dec_i.valid && !stall_o;
        exe_d.op_a     = rs1_data;
        exe_d.op_b     = dec_i.use_imm ? dec_i.imm : rs2_data;
        exe_d.alu_op   = dec_i.alu_op;
        exe_d.rd       = dec_i.rd;
        exe_d.write_rd = dec_i.write_rd;
        exe_d.illegal  = dec_i.illegal;
    end

    // ------------------------------------------------------------------
    // State update
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
                pend_q[i] <= '0;
            end
            exe_o.valid <= 1'b0;
        end else begin
            // Write port, x0 stays zero
            if (dec_cnt) begin
                regs_q[wb_rd_i] <= wb_data_i;
            end

            // Issue and retire on the same register cancel out
            if (inc_cnt && !(dec_cnt && same_reg)) begin
                pend_q[dec_i.rd] <= pend_q[dec_i.rd] + 2'd1;
            end
            if (dec_cnt && !(inc_cnt && same_reg)) begin
                pend_q[wb_rd_i] <= pend_q[wb_rd_i] - 2'd1;
            end

            if (!hold_i) begin
                exe_o <= exe_d;
            end
        end
    end

endmodule

// ==== logic/inst_decoder.sv ====
module inst_decoder (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  hold_i,
    input  logic                  inst_valid_i,
    input  rv_pipe_pkg::word_t    inst_word_i,
    output rv_pipe_pkg::dec_pkt_t dec_o
);

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    rv_pipe_pkg::dec_pkt_t dec_d;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic                  legal;

    assign opcode = inst_word_i[6:0];
    assign funct3 = inst_word_i[14:12];
    assign funct7 = inst_word_i[31:25];

    always_comb begin
        dec_d          = '0;
        legal          = 1'b1;
        dec_d.valid    = inst_valid_i;
        dec_d.rs1      = inst_word_i[19:15];
        dec_d.rs2      = inst_word_i[24:20];
        dec_d.rd       = inst_word_i[11:7];
        // I-type immediate by default
        dec_d.imm      = {{20{inst_word_i[31]}}, inst_word_i[31:20]};
        dec_d.alu_op   = rv_pipe_pkg::ADD;

        case (opcode)
            OPC_OP: begin
                dec_d.read_rs1 = (dec_d.rs1 != '0);
                dec_d.read_rs2 = (dec_d.rs2 != '0);
                dec_d.write_rd = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec_d.alu_op = rv_pipe_pkg::ADD;
                    {7'h20, 3'b000}: dec_d.alu_op = rv_pipe_pkg::SUB;
                    {7'h00, 3'b001}: dec_d.alu_op = rv_pipe_pkg::SLL;
                    {7'h00, 3'b010}: dec_d.alu_op = rv_pipe_pkg::SLT;
                    {7'h00, 3'b100}: dec_d.alu_op = rv_pipe_pkg::XOR;
                    {7'h00, 3'b101}: dec_d.alu_op = rv_pipe_pkg::SRL;
                    {7'h00, 3'b110}: dec_d.alu_op = rv_pipe_pkg::OR;
                    {7'h00, 3'b111}: dec_d.alu_op = rv_pipe_pkg::AND;
                    default:         legal        = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                dec_d.read_rs1 = (dec_d.rs1 != '0);
                dec_d.write_rd = 1'b1;
                dec_d.use_imm  = 1'b1;
                // Shift-immediates and SLTIU not supported
                case (funct3)
                    3'b000:  dec_d.alu_op = rv_pipe_pkg::ADD;
                    3'b010:  dec_d.alu_op = rv_pipe_pkg::SLT;
                    3'b100:  dec_d.alu_op = rv_pipe_pkg::XOR;
                    3'b110:  dec_d.alu_op = rv_pipe_pkg::OR;
                    3'b111:  dec_d.alu_op = rv_pipe_pkg::AND;
                    default: legal        = 1'b0;
                endcase
            end
            OPC_LUI: begin
                dec_d.write_rd = 1'b1;
                dec_d.use_imm  = 1'b1;
                dec_d.imm      = {inst_word_i[31:12], 12'b0};
                dec_d.alu_op   = rv_pipe_pkg::PASS_B;
            end
            default: legal = 1'b0;
        endcase

        // Illegal still retires, but touches no register
        if (!legal) begin
            dec_d.read_rs1 = 1'b0;
            dec_d.read_rs2 = 1'b0;
            dec_d.write_rd = 1'b0;
            dec_d.rd       = '0;
            dec_d.illegal  = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            dec_o.valid <= 1'b0;
        end else if (!hold_i) begin
            dec_o <= dec_d;
        end
    end

endmodule

// ==== logic/fetch_port.sv ====
module fetch_port (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               inst_req_i,
    input  rv_pipe_pkg::word_t inst_i,
    output logic               inst_ack_o,
    input  logic               hold_i,
    output logic               inst_valid_o,
    output rv_pipe_pkg::word_t inst_word_o
);

    rv_pipe_pkg::fetch_state_e state_q;
    logic                      slot_free;
    logic                      accept;

    // Slot is free if empty or the decoder takes the word this cycle
    assign slot_free = !inst_valid_o || !hold_i;
    assign accept    = (state_q == rv_pipe_pkg::IDLE) && inst_req_i && slot_free;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q      <= rv_pipe_pkg::IDLE;
            inst_valid_o <= 1'b0;
        end else begin
            case (state_q)
                rv_pipe_pkg::IDLE: begin
                    if (accept) begin
                        state_q <= rv_pipe_pkg::ACK;
                    end
                end
                // First ack cycle, req may still be high
                rv_pipe_pkg::ACK: begin
                    state_q <= inst_req_i ? rv_pipe_pkg::WAIT_DROP : rv_pipe_pkg::IDLE;
                end
                rv_pipe_pkg::WAIT_DROP: begin
                    if (!inst_req_i) begin
                        state_q <= rv_pipe_pkg::IDLE;
                    end
                end
                default: state_q <= rv_pipe_pkg::IDLE;
            endcase

            // New word wins over the one being taken
            if (accept) begin
                inst_valid_o <= 1'b1;
            end else if (!hold_i) begin
                inst_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            inst_word_o <= inst_i;
        end
    end

    assign inst_ack_o = (state_q != rv_pipe_pkg::IDLE);

endmodule

// ==== logic/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    // ------------------------------------------------------------------
    // Width types
    // ------------------------------------------------------------------

    // Data and instruction word
    typedef logic [31:0] word_t;
    // Architectural register index
    typedef logic [4:0]  reg_idx_t;
    // Outstanding writers per register, saturates at 3
    typedef logic [1:0]  pend_cnt_t;

    // ------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------

    // ALU operation, PASS_B forwards operand b (LUI)
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SLT,
        PASS_B
    } alu_op_e;

    // Input port handshake phases
    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_DROP
    } fetch_state_e;

    // ------------------------------------------------------------------
    // Stage packets
    // ------------------------------------------------------------------

    // Decoder to register file
    typedef struct packed {
        logic     valid;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     read_rs1;
        logic     read_rs2;
        reg_idx_t rd;
        logic     write_rd;
        word_t    imm;
        logic     use_imm;
        alu_op_e  alu_op;
        logic     illegal;
    } dec_pkt_t;

    // Issue to ALU
    typedef struct packed {
        logic     valid;
        word_t    op_a;
        word_t    op_b;
        alu_op_e  alu_op;
        reg_idx_t rd;
        logic     write_rd;
        logic     illegal;
    } exe_pkt_t;

    // ALU to write-back
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     write_rd;
        word_t    result;
        logic     illegal;
    } wb_pkt_t;

    // Retire port content
    typedef struct packed {
        reg_idx_t rd;
        word_t    result;
        logic     illegal;
    } retire_t;

endpackage
